// File: rtl/cachePkg.sv
`default_nettype none

package cachePkg;

  // data path widths
  localparam int XLEN     = 64;
  localparam int ADDR_W   = 32;

  // line geometry, 4 words of 8 bytes
  localparam int BEATS    = 4;
  localparam int OFFSET_W = 5;

  // one data word
  typedef logic [XLEN-1:0] word_t;

  // byte address
  typedef logic [ADDR_W-1:0] addr_t;

  // word index inside a line, address bits 4:3
  typedef logic [1:0] beat_t;

  // controller states
  typedef enum logic [2:0] {
    IDLE,
    COMPARE,
    LINE_REQ,
    REFILL,
    FILL
  } cacheState_e;

endpackage

`default_nettype wire

// File: rtl/refillCounter.sv
`default_nettype none

module refillCounter (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  start_i,
  input  wire                  beatValid_i,
  input  wire cachePkg::beat_t reqWord_i,
  output cachePkg::beat_t      beatIdx_o,
  output logic                 capture_o,
  output logic                 beatLast_o
);

  import cachePkg::*;

  beat_t count;

  // beats arrive in word order, so the count is the word index
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (start_i) begin
      count <= '0;
    end else if (beatValid_i) begin
      count <= count + beat_t'(1);
    end
  end

  assign beatIdx_o = count;

  // the beat carrying the word the load asked for
  assign capture_o = beatValid_i && (count == reqWord_i);

  // fourth beat closes the line
  assign beatLast_o = beatValid_i && (count == beat_t'(BEATS - 1));

endmodule

`default_nettype wire

// File: rtl/tagStore.sv
`default_nettype none

module tagStore #(
  parameter int SETS = 64,
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cachePkg::ADDR_W - cachePkg::OFFSET_W - IDX_W
) (
  input  wire              clk,
  input  wire              rst_n,
  input  wire              lookupEn_i,
  input  wire [IDX_W-1:0]  lookupIndex_i,
  input  wire [TAG_W-1:0]  reqTag_i,
  input  wire              tagWrite_i,
  input  wire              fillWay_i,
  input  wire              lruTouch_i,
  output logic             hit_o,
  output logic             hitWay_o,
  output logic             victimWay_o
);

  logic [TAG_W-1:0]         tagArr [2][SETS];
  logic [1:0][SETS-1:0]     validBits;
  logic [SETS-1:0]          lru;
  logic [TAG_W-1:0]         tagQ [2];
  logic [IDX_W-1:0]         idxQ;
  logic                     valid0;
  logic                     valid1;
  logic                     hit0;
  logic                     hit1;

  // tags read on lookup, written at the end of a refill
  always_ff @(posedge clk) begin
    if (tagWrite_i) begin
      tagArr[fillWay_i][idxQ] <= reqTag_i;
    end
    if (lookupEn_i) begin
      tagQ[0] <= tagArr[0][lookupIndex_i];
      tagQ[1] <= tagArr[1][lookupIndex_i];
    end
  end

  // idxQ stays on the missed set until the fill is done
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      idxQ      <= '0;
      validBits <= '0;
      lru       <= '0;
    end else begin
      if (lookupEn_i) begin
        idxQ <= lookupIndex_i;
      end
      if (tagWrite_i) begin
        validBits[fillWay_i][idxQ] <= 1'b1;
        lru[idxQ]                  <= ~fillWay_i;
      end else if (lruTouch_i) begin
        lru[idxQ] <= ~hitWay_o;
      end
    end
  end

  // valid and lru are flops, read live so a touch in the previous cycle is seen
  assign valid0 = validBits[0][idxQ];
  assign valid1 = validBits[1][idxQ];

  assign hit0 = valid0 && (tagQ[0] == reqTag_i);
  assign hit1 = valid1 && (tagQ[1] == reqTag_i);

  assign hit_o    = hit0 || hit1;
  assign hitWay_o = hit1;

  // empty way first, way 0 before way 1
  always_comb begin
    if (!valid0) begin
      victimWay_o = 1'b0;
    end else if (!valid1) begin
      victimWay_o = 1'b1;
    end else begin
      victimWay_o = lru[idxQ];
    end
  end

endmodule

`default_nettype wire

// File: rtl/dataStore.sv
`default_nettype none

module dataStore #(
  parameter int SETS = 64,
  localparam int IDX_W = $clog2(SETS)
) (
  input  wire                  clk,
  input  wire                  lookupEn_i,
  input  wire [IDX_W-1:0]      lookupIndex_i,
  input  wire cachePkg::beat_t wordSel_i,
  input  wire                  hitWay_i,
  input  wire                  fillEn_i,
  input  wire                  fillWay_i,
  input  wire [IDX_W-1:0]      fillIndex_i,
  input  wire cachePkg::beat_t beatIdx_i,
  input  wire cachePkg::word_t beatData_i,
  input  wire                  capture_i,
  input  wire                  respFromFill_i,
  output cachePkg::word_t      rdData_o
);

  import cachePkg::*;

  // one word per entry, entry address is {set, word}
  word_t lineMem [2][SETS*BEATS];
  word_t rdWord [2];
  word_t fillWord;

  always_ff @(posedge clk) begin
    // refill beats land in the victim way
    if (fillEn_i) begin
      lineMem[fillWay_i][{fillIndex_i, beatIdx_i}] <= beatData_i;
    end
    // both ways read, hit way picked in compare
    if (lookupEn_i) begin
      rdWord[0] <= lineMem[0][{lookupIndex_i, wordSel_i}];
      rdWord[1] <= lineMem[1][{lookupIndex_i, wordSel_i}];
    end
  end

  // requested word kept aside for the fill answer
  always_ff @(posedge clk) begin
    if (capture_i) begin
      fillWord <= beatData_i;
    end
  end

  assign rdData_o = respFromFill_i ? fillWord : rdWord[hitWay_i];

endmodule

`default_nettype wire

// File: rtl/cacheCtrl.sv
`default_nettype none

module cacheCtrl #(
  parameter int SETS        = 64,
  parameter int MEM_CREDITS = 2,
  localparam int IDX_W = $clog2(SETS),
  localparam int TAG_W = cachePkg::ADDR_W - cachePkg::OFFSET_W - IDX_W
) (
  input  wire                   clk,
  input  wire                   rst_n,
  input  wire                   valid_i,
  input  wire cachePkg::addr_t  addr_i,
  input  wire                   hit_i,
  input  wire                   victimWay_i,
  input  wire                   beatLast_i,
  input  wire                   memCredit_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output logic                  lookupEn_o,
  output logic [IDX_W-1:0]      lookupIndex_o,
  output logic [TAG_W-1:0]      reqTag_o,
  output cachePkg::beat_t       reqWord_o,
  output logic                  memReq_o,
  output cachePkg::addr_t       memAddr_o,
  output logic                  refillStart_o,
  output logic                  fillEn_o,
  output logic                  fillWay_o,
  output logic                  tagWrite_o,
  output logic                  lruTouch_o,
  output logic                  respFromFill_o
);

  import cachePkg::*;

  localparam int CRED_W = $clog2(MEM_CREDITS + 1);

  cacheState_e       state;
  cacheState_e       stateNext;
  addr_t             reqAddr;
  logic              fillWayQ;
  logic [CRED_W-1:0] credits;
  logic              accept;
  logic              hasCredit;

  // a new load may enter in idle, or behind a hit
  assign addrOk_o  = (state == IDLE) || ((state == COMPARE) && hit_i);
  assign accept    = valid_i && addrOk_o;
  assign hasCredit = (credits != '0);

  // line request goes out straight from compare when a credit is held
  assign memReq_o = hasCredit &&
                    (((state == COMPARE) && !hit_i) || (state == LINE_REQ));

  always_comb begin
    stateNext = state;
    case (state)
      IDLE: begin
        if (valid_i) begin
          stateNext = COMPARE;
        end
      end
      COMPARE: begin
        if (hit_i) begin
          stateNext = valid_i ? COMPARE : IDLE;
        end else begin
          stateNext = memReq_o ? REFILL : LINE_REQ;
        end
      end
      LINE_REQ: begin
        if (memReq_o) begin
          stateNext = REFILL;
        end
      end
      REFILL: begin
        if (beatLast_i) begin
          stateNext = FILL;
        end
      end
      FILL: begin
        stateNext = IDLE;
      end
      default: begin
        stateNext = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= IDLE;
      fillWayQ <= 1'b0;
    end else begin
      state <= stateNext;
      // victim is fixed once the miss is seen
      if ((state == COMPARE) && !hit_i) begin
        fillWayQ <= victimWay_i;
      end
    end
  end

  // request address, held until the next acceptance
  always_ff @(posedge clk) begin
    if (accept) begin
      reqAddr <= addr_i;
    end
  end

  // credit count, one spent per line request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits <= CRED_W'(MEM_CREDITS);
    end else begin
      case ({memReq_o, memCredit_i})
        2'b10:   credits <= credits - CRED_W'(1);
        2'b01:   credits <= credits + CRED_W'(1);
        default: credits <= credits;
      endcase
    end
  end

  // index and word follow the incoming load while accepting, else the held one
  assign lookupEn_o    = accept;
  assign lookupIndex_o = addrOk_o ? addr_i[OFFSET_W +: IDX_W] : reqAddr[OFFSET_W +: IDX_W];
  assign reqWord_o     = addrOk_o ? addr_i[OFFSET_W-1 -: 2] : reqAddr[OFFSET_W-1 -: 2];
  assign reqTag_o      = reqAddr[ADDR_W-1 -: TAG_W];

  assign memAddr_o     = {reqAddr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  assign refillStart_o = memReq_o;

  assign fillEn_o       = (state == REFILL);
  assign fillWay_o      = fillWayQ;
  assign tagWrite_o     = (state == FILL);
  assign lruTouch_o     = (state == COMPARE) && hit_i;
  assign respFromFill_o = (state == FILL);

  // hit answers in compare, miss answers in fill
  assign dataOk_o = ((state == COMPARE) && hit_i) || (state == FILL);

endmodule

`default_nettype wire

// File: rtl/cacheTop.sv
`default_nettype none

module cacheTop #(
  parameter int SETS        = 64,
  parameter int MEM_CREDITS = 2
) (
  input  wire                   clk,
  input  wire                   rst_n,
  // load side
  input  wire                   valid_i,
  input  wire cachePkg::addr_t  addr_i,
  output logic                  addrOk_o,
  output logic                  dataOk_o,
  output cachePkg::word_t       rdData_o,
  // memory request channel
  output logic                  memReq_o,
  output cachePkg::addr_t       memAddr_o,
  input  wire                   memCredit_i,
  // memory beat channel
  input  wire                   memBeatValid_i,
  input  wire cachePkg::word_t  memBeatData_i,
  input  wire                   memBeatLast_i
);

  import cachePkg::*;

  localparam int IDX_W = $clog2(SETS);
  localparam int TAG_W = ADDR_W - OFFSET_W - IDX_W;

  logic             hit;
  logic             hitWay;
  logic             victimWay;
  logic             lookupEn;
  logic [IDX_W-1:0] lookupIndex;
  logic [TAG_W-1:0] reqTag;
  beat_t            reqWord;
  logic             refillStart;
  logic             fillEn;
  logic             fillWay;
  logic             tagWrite;
  logic             lruTouch;
  logic             respFromFill;
  beat_t            beatIdx;
  logic             capture;
  logic             beatLast;
  logic             beatWrite;
  logic             refillDone;

  // write only on real beats during refill
  assign beatWrite  = fillEn && memBeatValid_i;
  // fourth beat, confirmed by the memory's last flag
  assign refillDone = beatLast && memBeatLast_i;

  cacheCtrl #(
    .SETS        (SETS),
    .MEM_CREDITS (MEM_CREDITS)
  ) ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid_i),
    .addr_i         (addr_i),
    .hit_i          (hit),
    .victimWay_i    (victimWay),
    .beatLast_i     (refillDone),
    .memCredit_i    (memCredit_i),
    .addrOk_o       (addrOk_o),
    .dataOk_o       (dataOk_o),
    .lookupEn_o     (lookupEn),
    .lookupIndex_o  (lookupIndex),
    .reqTag_o       (reqTag),
    .reqWord_o      (reqWord),
    .memReq_o       (memReq_o),
    .memAddr_o      (memAddr_o),
    .refillStart_o  (refillStart),
    .fillEn_o       (fillEn),
    .fillWay_o      (fillWay),
    .tagWrite_o     (tagWrite),
    .lruTouch_o     (lruTouch),
    .respFromFill_o (respFromFill)
  );

  refillCounter beatCount (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (refillStart),
    .beatValid_i (memBeatValid_i),
    .reqWord_i   (reqWord),
    .beatIdx_o   (beatIdx),
    .capture_o   (capture),
    .beatLast_o  (beatLast)
  );

  tagStore #(
    .SETS (SETS)
  ) tags (
    .clk           (clk),
    .rst_n         (rst_n),
    .lookupEn_i    (lookupEn),
    .lookupIndex_i (lookupIndex),
    .reqTag_i      (reqTag),
    .tagWrite_i    (tagWrite),
    .fillWay_i     (fillWay),
    .lruTouch_i    (lruTouch),
    .hit_o         (hit),
    .hitWay_o      (hitWay),
    .victimWay_o   (victimWay)
  );

  // fill index is the held request index while refilling
  dataStore #(
    .SETS (SETS)
  ) data (
    .clk            (clk),
    .lookupEn_i     (lookupEn),
    .lookupIndex_i  (lookupIndex),
    .wordSel_i      (reqWord),
    .hitWay_i       (hitWay),
    .fillEn_i       (beatWrite),
    .fillWay_i      (fillWay),
    .fillIndex_i    (lookupIndex),
    .beatIdx_i      (beatIdx),
    .beatData_i     (memBeatData_i),
    .capture_i      (capture),
    .respFromFill_i (respFromFill),
    .rdData_o       (rdData_o)
  );

endmodule

`default_nettype wire

// File: sim/memModel.sv
`default_nettype none

module memModel #(
  parameter int CREDITS      = 1,
  parameter int DELAY        = 3,
  parameter int CREDIT_DELAY = 12
) (
  input  wire                  clk,
  input  wire                  rst_n,
  input  wire                  memReq_i,
  input  wire cachePkg::addr_t memAddr_i,
  output logic                 memCredit_o,
  output logic                 beatValid_o,
  output cachePkg::word_t      beatData_o,
  output logic                 beatLast_o,
  output int                   reqCount_o,
  output int                   violations_o
);

  timeunit 1ns;
  timeprecision 1ps;

  import cachePkg::*;

  addr_t lineAddr;
  addr_t beatAddr;
  logic  busy;
  int    credits;
  int    waitCnt;
  int    beatCnt;
  int    creditCnt;

  // word at byte address A is {~A, A}
  assign beatAddr   = lineAddr + addr_t'(beatCnt * 8);

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      memCredit_o  <= 1'b0;
      beatValid_o  <= 1'b0;
      beatData_o   <= '0;
      beatLast_o   <= 1'b0;
      reqCount_o   <= 0;
      violations_o <= 0;
      lineAddr     <= '0;
      busy         <= 1'b0;
      credits      <= CREDITS;
      waitCnt      <= 0;
      beatCnt      <= 0;
      creditCnt    <= 0;
    end else begin
      beatValid_o <= 1'b0;
      beatLast_o  <= 1'b0;
      memCredit_o <= 1'b0;
      // same accounting edge as the cache sees
      credits <= credits - int'(memReq_i) + int'(memCredit_o);
      if (memReq_i) begin
        reqCount_o <= reqCount_o + 1;
        if (credits == 0) begin
          $display("memory request for line %h arrived without a credit", memAddr_i);
          violations_o <= violations_o + 1;
        end
        if (busy) begin
          $display("memory request for line %h arrived during a refill", memAddr_i);
          violations_o <= violations_o + 1;
        end
        lineAddr <= memAddr_i;
        busy     <= 1'b1;
        waitCnt  <= DELAY - 1;
        beatCnt  <= 0;
      end else if (busy) begin
        if (waitCnt != 0) begin
          waitCnt <= waitCnt - 1;
        end else begin
          beatValid_o <= 1'b1;
          beatData_o  <= {~beatAddr, beatAddr};
          beatCnt     <= beatCnt + 1;
          if (beatCnt == BEATS - 1) begin
            beatLast_o <= 1'b1;
            busy       <= 1'b0;
            creditCnt  <= CREDIT_DELAY;
          end
        end
      end
      // credit goes back some time after the last beat
      if (creditCnt != 0) begin
        creditCnt <= creditCnt - 1;
        if (creditCnt == 1) begin
          memCredit_o <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: sim/cacheTop_tb.sv
`default_nettype none

module cacheTop_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import cachePkg::*;

  localparam int SETS           = 64;
  localparam int MEM_CREDITS    = 1;
  localparam int IDX_W          = $clog2(SETS);
  localparam int NUM_ENTRIES    = 20;
  localparam int RESET_CYCLES   = 5;
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 40;

  logic  clk;
  logic  rst_n;
  logic  valid;
  addr_t addr;
  logic  addrOk;
  logic  dataOk;
  word_t rdData;
  logic  memReq;
  addr_t memAddr;
  logic  memCredit;
  logic  beatValid;
  word_t beatData;
  logic  beatLast;
  int    reqCount;
  int    violations;

  // stimulus table
  addr_t stimAddr [NUM_ENTRIES];
  bit    stimHit  [NUM_ENTRIES];
  bit    stimB2b  [NUM_ENTRIES];

  // reference 2-way LRU sets
  addr_t refTag   [2][SETS];
  bit    refValid [2][SETS];
  bit    refLru   [SETS];

  word_t expWordQ [$];
  bit    expHitQ [$];
  int    expCycleQ [$];
  addr_t missLineQ [$];
  int    missCycleQ [$];

  int valueErrors = 0;
  int protoErrors = 0;
  int cycleCount  = 0;
  int creditsHeld = MEM_CREDITS;
  int creditCycle = -2;
  int missCount   = 0;
  bit fillPending = 1'b0;

  cacheTop #(
    .SETS        (SETS),
    .MEM_CREDITS (MEM_CREDITS)
  ) UUT (
    .clk            (clk),
    .rst_n          (rst_n),
    .valid_i        (valid),
    .addr_i         (addr),
    .addrOk_o       (addrOk),
    .dataOk_o       (dataOk),
    .rdData_o       (rdData),
    .memReq_o       (memReq),
    .memAddr_o      (memAddr),
    .memCredit_i    (memCredit),
    .memBeatValid_i (beatValid),
    .memBeatData_i  (beatData),
    .memBeatLast_i  (beatLast)
  );

  memModel #(
    .CREDITS (MEM_CREDITS)
  ) mem (
    .clk          (clk),
    .rst_n        (rst_n),
    .memReq_i     (memReq),
    .memAddr_i    (memAddr),
    .memCredit_o  (memCredit),
    .beatValid_o  (beatValid),
    .beatData_o   (beatData),
    .beatLast_o   (beatLast),
    .reqCount_o   (reqCount),
    .violations_o (violations)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic checkWord(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      valueErrors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkAddr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      valueErrors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      valueErrors++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic setEntry(input int i, input addr_t a, input bit hit, input bit b2b);
    stimAddr[i] = a;
    stimHit[i]  = hit;
    stimB2b[i]  = b2b;
  endtask

  task automatic fillTable();
    // cold miss followed by hits on the same line
    setEntry(0,  32'h0000_1000, 1'b0, 1'b0);
    setEntry(1,  32'h0000_1008, 1'b1, 1'b0);
    setEntry(2,  32'h0000_1010, 1'b1, 1'b0);
    setEntry(3,  32'h0000_1018, 1'b1, 1'b1);
    setEntry(4,  32'h0000_1000, 1'b1, 1'b1);
    setEntry(5,  32'h0000_1008, 1'b1, 1'b0);
    // cold misses on word offsets 1 to 3
    setEntry(6,  32'h0000_1028, 1'b0, 1'b0);
    setEntry(7,  32'h0000_1050, 1'b0, 1'b0);
    setEntry(8,  32'h0000_1078, 1'b0, 1'b0);
    // set 5 with tags A B C and two misses in a row on one credit
    setEntry(9,  32'h0000_00A0, 1'b0, 1'b1);
    setEntry(10, 32'h0000_08A8, 1'b0, 1'b0);
    setEntry(11, 32'h0000_00B8, 1'b1, 1'b0);
    setEntry(12, 32'h0000_10A0, 1'b0, 1'b0);
    setEntry(13, 32'h0000_00A0, 1'b1, 1'b0);
    setEntry(14, 32'h0000_08A0, 1'b0, 1'b0);
    setEntry(15, 32'h0000_00B0, 1'b1, 1'b0);
    setEntry(16, 32'h0000_10A8, 1'b0, 1'b0);
    // hit on way 1 with a new tag right behind it
    setEntry(17, 32'h0000_10B8, 1'b1, 1'b1);
    setEntry(18, 32'h0000_18A0, 1'b0, 1'b0);
    setEntry(19, 32'h0000_10A0, 1'b1, 1'b0);
  endtask

  function automatic word_t expectedWord(input addr_t a);
    addr_t wa;
    wa = {a[ADDR_W-1:3], 3'b000};
    return {~wa, wa};
  endfunction

  function automatic addr_t lineOf(input addr_t a);
    return {a[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
  endfunction

  // looks up and updates the reference sets and returns the hit flag
  function automatic bit refLookup(input addr_t a);
    int    idx;
    addr_t tag;
    bit    way;
    bit    hitFlag;
    idx     = int'(a[OFFSET_W +: IDX_W]);
    tag     = a >> (OFFSET_W + IDX_W);
    hitFlag = 1'b1;
    if (refValid[0][idx] && refTag[0][idx] == tag) begin
      way = 1'b0;
    end else if (refValid[1][idx] && refTag[1][idx] == tag) begin
      way = 1'b1;
    end else begin
      hitFlag = 1'b0;
      if (!refValid[0][idx]) begin
        way = 1'b0;
      end else if (!refValid[1][idx]) begin
        way = 1'b1;
      end else begin
        way = refLru[idx];
      end
      refValid[way][idx] = 1'b1;
      refTag[way][idx]   = tag;
    end
    refLru[idx] = ~way;
    return hitFlag;
  endfunction

  // cycle counter and run limit
  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= TIMEOUT_CYCLES) begin
      $display("timeout, run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAILED");
      $finish;
    end
  end

  // response and memory request monitor
  always @(negedge clk) begin
    word_t w;
    bit    h;
    int    c;
    int    mc;
    if (rst_n) begin
      if (memReq) begin
        if (creditsHeld == 0) begin
          protoErrors++;
          $display("memory request issued with no credit left");
        end
        if (missLineQ.size() == 0) begin
          protoErrors++;
          $display("unexpected memory request for line %h", memAddr);
        end else begin
          mc = missCycleQ.pop_front();
          checkAddr("memAddr_o", memAddr, missLineQ.pop_front());
          // one cycle after the miss is accepted, or after the credit comes back
          if (cycleCount != mc + 1 && cycleCount != creditCycle + 1) begin
            protoErrors++;
            $display("line request for %h issued %0d cycles after acceptance",
                     memAddr, cycleCount - mc);
          end
        end
      end
      if (memCredit) begin
        creditCycle = cycleCount;
      end
      creditsHeld = creditsHeld - int'(memReq) + int'(memCredit);
      if (fillPending && !dataOk) begin
        protoErrors++;
        $display("no response in the cycle after the last refill beat");
      end
      fillPending = beatValid && beatLast;
      if (dataOk) begin
        if (expWordQ.size() == 0) begin
          protoErrors++;
          $display("response without an outstanding load");
        end else begin
          w = expWordQ.pop_front();
          h = expHitQ.pop_front();
          c = expCycleQ.pop_front();
          checkWord("rdData_o", rdData, w);
          if (h && cycleCount != c + 1) begin
            protoErrors++;
            $display("hit answered %0d cycles after acceptance", cycleCount - c);
          end
        end
      end
    end
  end

  initial begin
    int acceptCycle;
    int lastAccept;
    bit hitRef;
    bit needNext;
    valid      = 1'b0;
    addr       = '0;
    rst_n      = 1'b0;
    lastAccept = 0;
    needNext   = 1'b0;
    fillTable();
    repeat (RESET_CYCLES) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    checkBit("dataOk_o", dataOk, 1'b0);
    checkBit("memReq_o", memReq, 1'b0);
    checkBit("addrOk_o", addrOk, 1'b1);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      valid = 1'b1;
      addr  = stimAddr[i];
      while (!addrOk) @(negedge clk);
      // accepted on the coming rising edge
      acceptCycle = cycleCount;
      if (needNext && acceptCycle != lastAccept + 1) begin
        protoErrors++;
        $display("load %0d behind a hit was not accepted in the next cycle", i);
      end
      hitRef = refLookup(stimAddr[i]);
      if (hitRef != stimHit[i]) begin
        protoErrors++;
        $display("table entry %0d disagrees with the reference LRU model", i);
      end
      expWordQ.push_back(expectedWord(stimAddr[i]));
      expHitQ.push_back(hitRef);
      expCycleQ.push_back(acceptCycle);
      if (!hitRef) begin
        missLineQ.push_back(lineOf(stimAddr[i]));
        missCycleQ.push_back(acceptCycle);
        missCount++;
      end
      needNext   = stimB2b[i] && hitRef;
      lastAccept = acceptCycle;
      @(negedge clk);
      if (!stimB2b[i]) begin
        valid = 1'b0;
        while (expWordQ.size() != 0) @(negedge clk);
      end
    end
    valid = 1'b0;
    while (expWordQ.size() != 0) @(negedge clk);
    // let the last credit come home
    repeat (20) @(negedge clk);
    if (missLineQ.size() != 0) begin
      protoErrors++;
      $display("%0d line requests never issued", missLineQ.size());
    end
    if (reqCount != missCount) begin
      protoErrors++;
      $display("memory saw %0d requests for %0d misses", reqCount, missCount);
    end
    if (creditsHeld != MEM_CREDITS) begin
      protoErrors++;
      $display("credits not all returned at the end");
    end
    $display("errors: value %0d, protocol %0d, memory %0d",
             valueErrors, protoErrors, violations);
    if (valueErrors + protoErrors + violations == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: cacheTop.f
rtl/cachePkg.sv
rtl/refillCounter.sv
rtl/tagStore.sv
rtl/dataStore.sv
rtl/cacheCtrl.sv
rtl/cacheTop.sv
sim/memModel.sv
sim/cacheTop_tb.sv

// File: Makefile
# Verilator simulation of the cache testbench

VERILATOR ?= verilator
TOP       ?= cacheTop_tb
FILELIST  ?= cacheTop.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
